/* verilog/i2c_pkg.sv */
`default_nettype none

package i2c_pkg;

	// bus addressing
	localparam logic [6:0] SLAVE_ADDR = 7'h48; // device address of the memory slave
	localparam int MEM_DEPTH = 16; // bytes held by the slave
	localparam int MEM_AW = $clog2(MEM_DEPTH); // slave byte pointer width
	localparam logic [7:0] MEM_LIMIT = 8'(MEM_DEPTH); // first memory address refused

	// serial clock timing
	localparam int SCL_DIV = 4; // sclk cycles per scl quarter
	localparam int DIV_W = $clog2(SCL_DIV); // quarter divider width
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SCL_DIV - 1); // end of a quarter

	// byte framing
	localparam int BIT_CNT_W = 3; // counts the 8 bits of a byte
	localparam logic [BIT_CNT_W-1:0] BIT_LAST = '1; // eighth bit of a byte

	// REG_CTRL bit positions
	localparam int CTRL_GO = 0; // write 1 to launch a transfer
	localparam int CTRL_BUSY = 0; // read side
	localparam int CTRL_NACK = 1;
	localparam int CTRL_DONE = 2; // done_seen flag

	// register map of the config block
	typedef enum logic [1:0]
	{
		REG_DEV = 2'd0, // {dev_addr, rw}
		REG_MEM = 2'd1, // memory address
		REG_DATA = 2'd2, // write data or read result
		REG_CTRL = 2'd3 // go on write, status on read
	} cfg_reg_e;

	// master sequencer, one state per bit group
	typedef enum logic [3:0]
	{
		MST_IDLE = 4'd0,
		MST_START = 4'd1,
		MST_DEV = 4'd2, // address and rw out
		MST_DEV_ACK = 4'd3,
		MST_MEM = 4'd4, // memory address out
		MST_MEM_ACK = 4'd5,
		MST_DATA = 4'd6, // byte out on write, in on read
		MST_DATA_ACK = 4'd7,
		MST_STOP = 4'd8
	} mst_state_e;

	// slave receiver states
	typedef enum logic [2:0]
	{
		SLV_WAIT_START = 3'd0,
		SLV_DEV = 3'd1,
		SLV_DEV_ACK = 3'd2,
		SLV_MEM = 3'd3,
		SLV_MEM_ACK = 3'd4,
		SLV_DATA = 3'd5,
		SLV_DATA_ACK = 3'd6
	} slv_state_e;

endpackage

`default_nettype wire

/* verilog/i2c_cfg_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_cfg_regs
(
	input wire sclk,
	input wire rst,
	input wire cfg_wr, // register write strobe
	input wire i2c_pkg::cfg_reg_e cfg_addr,
	input wire [7:0] cfg_wdata,
	output logic [7:0] cfg_rdata, // comb read mux
	input wire busy, // from master
	input wire done, // one cycle at end of transfer
	input wire nack_in, // valid with done
	input wire [7:0] rd_data, // valid with done
	output logic [6:0] dev_addr,
	output logic rw, // 1 = read
	output logic [7:0] mem_addr,
	output logic [7:0] wr_data,
	output logic start // one cycle launch pulse
);

	logic [7:0] dev_reg; // {dev_addr, rw}
	logic [7:0] mem_reg;
	logic [7:0] data_reg; // write byte, overwritten by a read result
	logic nack_flag; // status of last transfer
	logic done_seen; // set on done, cleared by next start
	logic go_wr; // control write asking for a transfer

	assign go_wr = cfg_wr && (cfg_addr == i2c_pkg::REG_CTRL) && cfg_wdata[i2c_pkg::CTRL_GO];

	always_ff @(posedge sclk)
	begin
		if (rst)
		begin
			dev_reg <= '0;
			mem_reg <= '0;
			data_reg <= '0;
			nack_flag <= 1'b0;
			done_seen <= 1'b0;
			start <= 1'b0;
		end
		else
		begin
			// busy rises a cycle late so a pulse in flight also blocks
			start <= go_wr && !busy && !start;
			if (cfg_wr)
			begin
				case (cfg_addr)
					i2c_pkg::REG_DEV: dev_reg <= cfg_wdata;
					i2c_pkg::REG_MEM: mem_reg <= cfg_wdata;
					i2c_pkg::REG_DATA: data_reg <= cfg_wdata;
					default: ; // ctrl has no storage
				endcase
			end
			if (start)
			begin
				done_seen <= 1'b0; // new transfer
				nack_flag <= 1'b0;
			end
			if (done)
			begin
				done_seen <= 1'b1;
				nack_flag <= nack_in;
				if (rw && !nack_in)
					data_reg <= rd_data; // keep write byte on writes and failed reads
			end
		end
	end

	always_comb
	begin
		cfg_rdata = '0;
		case (cfg_addr)
			i2c_pkg::REG_DEV: cfg_rdata = dev_reg;
			i2c_pkg::REG_MEM: cfg_rdata = mem_reg;
			i2c_pkg::REG_DATA: cfg_rdata = data_reg;
			i2c_pkg::REG_CTRL:
			begin
				cfg_rdata[i2c_pkg::CTRL_BUSY] = busy;
				cfg_rdata[i2c_pkg::CTRL_NACK] = nack_flag;
				cfg_rdata[i2c_pkg::CTRL_DONE] = done_seen;
			end
			default: cfg_rdata = '0;
		endcase
	end

	assign dev_addr = dev_reg[7:1];
	assign rw = dev_reg[0];
	assign mem_addr = mem_reg;
	assign wr_data = data_reg;

endmodule

`default_nettype wire

/* verilog/i2c_master.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_master
(
	input wire sclk,
	input wire rst,
	input wire start, // launch pulse, only seen in idle
	input wire [6:0] dev_addr,
	input wire rw, // 1 = read
	input wire [7:0] mem_addr,
	input wire [7:0] wr_data,
	input wire sda_in, // resolved bus line
	output logic scl,
	output logic sda_low, // pull-low enable
	output logic busy,
	output logic done, // one cycle
	output logic nack, // valid with done
	output logic [7:0] rd_data // valid with done
);

	i2c_pkg::mst_state_e state;
	logic [i2c_pkg::DIV_W-1:0] div_cnt; // sclk count inside a quarter
	logic [1:0] phase; // quarter of the bit, scl high in 2 and 3
	logic tick; // last cycle of a quarter
	logic bit_end; // last cycle of a bit
	logic sample; // scl rises on this edge
	logic [i2c_pkg::BIT_CNT_W-1:0] bit_cnt;
	logic [7:0] tx_shift; // msb goes on the line
	logic [7:0] rx_shift;
	logic [7:0] mem_q; // held for the second byte
	logic [7:0] wr_q; // held for the third byte
	logic rd_mode;
	logic ack_bit; // sda seen at the last rising edge

	assign tick = (div_cnt == i2c_pkg::DIV_LAST);
	assign bit_end = tick && (phase == 2'd3);
	assign sample = tick && (phase == 2'd1);
	assign rd_data = rx_shift;

	// quarter divider, parked while idle so a transfer starts at phase 0
	always_ff @(posedge sclk)
	begin
		if (rst)
		begin
			div_cnt <= '0;
			phase <= 2'd0;
		end
		else if (state == i2c_pkg::MST_IDLE)
		begin
			div_cnt <= '0;
			phase <= 2'd0;
		end
		else if (tick)
		begin
			div_cnt <= '0;
			phase <= phase + 2'd1;
		end
		else
			div_cnt <= div_cnt + 1'b1;
	end

	// line drive decoded from state and quarter
	always_comb
	begin
		scl = phase[1];
		sda_low = 1'b0; // ack bits released, read nack too
		case (state)
			i2c_pkg::MST_IDLE: scl = 1'b1;
			i2c_pkg::MST_START:
			begin
				scl = 1'b1;
				sda_low = phase[1]; // sda falls with scl high
			end
			i2c_pkg::MST_DEV: sda_low = ~tx_shift[7];
			i2c_pkg::MST_MEM: sda_low = ~tx_shift[7];
			i2c_pkg::MST_DATA: sda_low = ~tx_shift[7] & ~rd_mode; // slave drives on read
			i2c_pkg::MST_STOP: sda_low = (phase != 2'd3); // sda rises with scl high
			default: sda_low = 1'b0;
		endcase
	end

	always_ff @(posedge sclk)
	begin
		if (rst)
		begin
			state <= i2c_pkg::MST_IDLE;
			busy <= 1'b0;
			done <= 1'b0;
			nack <= 1'b0;
			bit_cnt <= '0;
			tx_shift <= '0;
			rx_shift <= '0;
			mem_q <= '0;
			wr_q <= '0;
			rd_mode <= 1'b0;
			ack_bit <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (sample)
			begin
				ack_bit <= sda_in;
				if (state == i2c_pkg::MST_DATA && rd_mode)
					rx_shift <= {rx_shift[6:0], sda_in}; // msb first
			end
			case (state)
				i2c_pkg::MST_IDLE:
				if (start)
				begin
					state <= i2c_pkg::MST_START;
					busy <= 1'b1;
					nack <= 1'b0;
					bit_cnt <= '0;
					tx_shift <= {dev_addr, rw};
					mem_q <= mem_addr;
					wr_q <= wr_data;
					rd_mode <= rw;
				end
				i2c_pkg::MST_START:
				if (bit_end)
					state <= i2c_pkg::MST_DEV;
				i2c_pkg::MST_DEV, i2c_pkg::MST_MEM, i2c_pkg::MST_DATA:
				if (bit_end)
				begin
					tx_shift <= {tx_shift[6:0], 1'b0};
					bit_cnt <= bit_cnt + 1'b1; // wraps to 0 for the next byte
					if (bit_cnt == i2c_pkg::BIT_LAST)
						state <= (state == i2c_pkg::MST_DEV) ? i2c_pkg::MST_DEV_ACK :
							(state == i2c_pkg::MST_MEM) ? i2c_pkg::MST_MEM_ACK :
							i2c_pkg::MST_DATA_ACK;
				end
				i2c_pkg::MST_DEV_ACK, i2c_pkg::MST_MEM_ACK:
				if (bit_end)
				begin
					if (ack_bit)
					begin
						nack <= 1'b1; // nobody answered, abort
						state <= i2c_pkg::MST_STOP;
					end
					else
					begin
						tx_shift <= (state == i2c_pkg::MST_DEV_ACK) ? mem_q : wr_q;
						state <= (state == i2c_pkg::MST_DEV_ACK) ? i2c_pkg::MST_MEM :
							i2c_pkg::MST_DATA;
					end
				end
				i2c_pkg::MST_DATA_ACK:
				if (bit_end)
				begin
					nack <= ack_bit & ~rd_mode; // on read the high bit is our own nack
					state <= i2c_pkg::MST_STOP;
				end
				i2c_pkg::MST_STOP:
				if (bit_end)
				begin
					busy <= 1'b0;
					done <= 1'b1;
					state <= i2c_pkg::MST_IDLE;
				end
				default: state <= i2c_pkg::MST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/i2c_slave_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_slave_mem
(
	input wire sclk,
	input wire rst,
	input wire scl, // from master
	input wire sda_in, // resolved bus line
	output logic sda_low // pull-low enable
);

	i2c_pkg::slv_state_e state;
	logic [1:0] scl_sync; // two flop synchronizer
	logic [1:0] sda_sync;
	logic scl_p; // previous synced value
	logic sda_p;
	logic scl_rise;
	logic scl_fall;
	logic start_det; // sda falls with scl high
	logic stop_det; // sda rises with scl high
	logic [i2c_pkg::BIT_CNT_W-1:0] bit_cnt;
	logic [7:0] rx_shift;
	logic [7:0] tx_shift; // remaining read bits, msb next
	logic [i2c_pkg::MEM_AW-1:0] mem_ptr;
	logic rd_mode; // rw bit of this transfer
	logic [7:0] mem [i2c_pkg::MEM_DEPTH];

	always_ff @(posedge sclk)
	begin
		if (rst)
		begin
			scl_sync <= 2'b11; // idle bus is high
			sda_sync <= 2'b11;
			scl_p <= 1'b1;
			sda_p <= 1'b1;
		end
		else
		begin
			scl_sync <= {scl_sync[0], scl};
			sda_sync <= {sda_sync[0], sda_in};
			scl_p <= scl_sync[1];
			sda_p <= sda_sync[1];
		end
	end

	assign scl_rise = scl_sync[1] & ~scl_p;
	assign scl_fall = ~scl_sync[1] & scl_p;
	assign start_det = scl_sync[1] & scl_p & sda_p & ~sda_sync[1];
	assign stop_det = scl_sync[1] & scl_p & ~sda_p & sda_sync[1];

	// sampling on scl rise, driving on scl fall
	// in the ack states sda_low tells the first fall from the second
	always_ff @(posedge sclk)
	begin
		if (rst)
		begin
			state <= i2c_pkg::SLV_WAIT_START;
			sda_low <= 1'b0;
			bit_cnt <= '0;
			rx_shift <= '0;
			tx_shift <= '0;
			mem_ptr <= '0;
			rd_mode <= 1'b0;
			for (int i = 0; i < i2c_pkg::MEM_DEPTH; i++)
				mem[i] <= '0;
		end
		else if (stop_det)
		begin
			state <= i2c_pkg::SLV_WAIT_START;
			sda_low <= 1'b0;
		end
		else if (start_det)
		begin
			state <= i2c_pkg::SLV_DEV; // also restarts a transfer in progress
			sda_low <= 1'b0;
			bit_cnt <= '0;
		end
		else
		begin
			case (state)
				i2c_pkg::SLV_WAIT_START: bit_cnt <= '0;
				i2c_pkg::SLV_DEV, i2c_pkg::SLV_MEM:
				if (scl_rise)
				begin
					rx_shift <= {rx_shift[6:0], sda_sync[1]};
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == i2c_pkg::BIT_LAST)
						state <= (state == i2c_pkg::SLV_DEV) ? i2c_pkg::SLV_DEV_ACK :
							i2c_pkg::SLV_MEM_ACK;
				end
				i2c_pkg::SLV_DEV_ACK:
				if (scl_fall)
				begin
					if (sda_low)
					begin
						sda_low <= 1'b0; // end of ack bit
						state <= i2c_pkg::SLV_MEM;
					end
					else if (rx_shift[7:1] == i2c_pkg::SLAVE_ADDR)
					begin
						sda_low <= 1'b1;
						rd_mode <= rx_shift[0];
					end
					else
						state <= i2c_pkg::SLV_WAIT_START; // not ours, stay silent
				end
				i2c_pkg::SLV_MEM_ACK:
				if (scl_fall)
				begin
					if (sda_low)
					begin
						state <= i2c_pkg::SLV_DATA;
						sda_low <= rd_mode & ~mem[mem_ptr][7]; // first read bit
						tx_shift <= {mem[mem_ptr][6:0], 1'b0};
					end
					else if (rx_shift < i2c_pkg::MEM_LIMIT)
					begin
						sda_low <= 1'b1;
						mem_ptr <= rx_shift[i2c_pkg::MEM_AW-1:0];
					end
					else
						state <= i2c_pkg::SLV_WAIT_START; // out of range
				end
				i2c_pkg::SLV_DATA:
				if (scl_rise)
				begin
					rx_shift <= {rx_shift[6:0], sda_sync[1]};
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == i2c_pkg::BIT_LAST)
						state <= i2c_pkg::SLV_DATA_ACK;
				end
				else if (scl_fall && rd_mode)
				begin
					sda_low <= ~tx_shift[7];
					tx_shift <= {tx_shift[6:0], 1'b0};
				end
				i2c_pkg::SLV_DATA_ACK:
				if (scl_fall)
				begin
					if (!rd_mode && !sda_low)
					begin
						mem[mem_ptr] <= rx_shift; // commit and ack
						sda_low <= 1'b1;
					end
					else
					begin
						sda_low <= 1'b0; // read leaves the ack bit to the master
						state <= i2c_pkg::SLV_WAIT_START;
					end
				end
				default: state <= i2c_pkg::SLV_WAIT_START;
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/i2c_top.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_top
(
	input wire sclk,
	input wire rst,
	input wire cfg_wr,
	input wire i2c_pkg::cfg_reg_e cfg_addr,
	input wire [7:0] cfg_wdata,
	output logic [7:0] cfg_rdata,
	output logic busy,
	output logic done,
	output logic nack,
	output logic scl,
	output logic sda // resolved open drain line
);

	logic [6:0] dev_addr;
	logic rw;
	logic [7:0] mem_addr;
	logic [7:0] wr_data;
	logic [7:0] rd_data;
	logic start;
	logic m_sda_low; // master pull-low
	logic s_sda_low; // slave pull-low

	// wired-AND with pull-up
	assign sda = ~(m_sda_low | s_sda_low);

	i2c_cfg_regs i2c_cfg_regs_inst
	(
		.sclk(sclk),
		.rst(rst),
		.cfg_wr(cfg_wr),
		.cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata),
		.cfg_rdata(cfg_rdata),
		.busy(busy),
		.done(done),
		.nack_in(nack),
		.rd_data(rd_data),
		.dev_addr(dev_addr),
		.rw(rw),
		.mem_addr(mem_addr),
		.wr_data(wr_data),
		.start(start)
	);

	i2c_master i2c_master_inst
	(
		.sclk(sclk),
		.rst(rst),
		.start(start),
		.dev_addr(dev_addr),
		.rw(rw),
		.mem_addr(mem_addr),
		.wr_data(wr_data),
		.sda_in(sda),
		.scl(scl),
		.sda_low(m_sda_low),
		.busy(busy),
		.done(done),
		.nack(nack),
		.rd_data(rd_data)
	);

	i2c_slave_mem i2c_slave_mem_inst
	(
		.sclk(sclk),
		.rst(rst),
		.scl(scl),
		.sda_in(sda),
		.sda_low(s_sda_low)
	);

endmodule

`default_nettype wire

/* tests/i2c_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_checker
(
	input wire sclk,
	input wire rst,
	input wire done, // dut transfer end pulse
	input wire nack,
	input wire busy,
	input wire scl, // bus clock, high while idle
	input wire sda, // bus data, high while idle
	input wire [7:0] cfg_rdata,
	input wire i2c_pkg::cfg_reg_e cfg_addr, // register being read
	input wire chk_en, // compare cfg_rdata this cycle
	input wire [7:0] chk_exp,
	input wire exp_nack, // expected nack at done
	input wire test_end, // closes one table entry
	input wire [7:0] test_num,
	input wire report, // print totals
	output int err_cnt
);

	int test_cnt;
	int fail_cnt; // tests with at least one error
	int test_errs; // errors inside the current test
	int done_cnt; // done pulses inside the current test
	logic busy_q; // busy one cycle back

	function automatic string reg_name(input i2c_pkg::cfg_reg_e a);
		case (a)
			i2c_pkg::REG_DEV: return "REG_DEV";
			i2c_pkg::REG_MEM: return "REG_MEM";
			i2c_pkg::REG_DATA: return "REG_DATA";
			default: return "REG_CTRL";
		endcase
	endfunction

	always @(posedge sclk)
	begin
		if (rst)
		begin
			err_cnt = 0;
			test_cnt = 0;
			fail_cnt = 0;
			test_errs = 0;
			done_cnt = 0;
			busy_q <= 1'b0;
		end
		else
		begin
			busy_q <= busy;
			if (!busy && (scl !== 1'b1)) // released bus between transfers
			begin
				$display("ERR %0t scl expected 1 actual %0b", $time, scl);
				test_errs = test_errs + 1;
			end
			if (!busy && (sda !== 1'b1))
			begin
				$display("ERR %0t sda expected 1 actual %0b", $time, sda);
				test_errs = test_errs + 1;
			end
			if (busy_q && !busy && !done) // busy only falls with done
			begin
				$display("busy dropped without a done pulse at %0t", $time);
				test_errs = test_errs + 1;
			end
			if (done)
			begin
				done_cnt = done_cnt + 1;
				if (nack !== exp_nack)
				begin
					$display("ERR %0t nack expected %0b actual %0b", $time, exp_nack, nack);
					test_errs = test_errs + 1;
				end
				if (!busy_q || busy) // busy must drop exactly with done
				begin
					$display("busy was not high up to the done pulse at %0t", $time);
					test_errs = test_errs + 1;
				end
			end
			if (chk_en && (cfg_rdata !== chk_exp))
			begin
				$display("ERR %0t cfg_rdata(%s) expected %02h actual %02h", $time,
					reg_name(cfg_addr), chk_exp, cfg_rdata);
				test_errs = test_errs + 1;
			end
			if (test_end)
			begin
				if (done_cnt != 1) // dropped start must not add a pulse
				begin
					$display("test %0d saw %0d done pulses instead of one", test_num, done_cnt);
					test_errs = test_errs + 1;
				end
				$display("test %0d %s", test_num, (test_errs == 0) ? "ok" : "failed");
				test_cnt = test_cnt + 1;
				if (test_errs != 0)
					fail_cnt = fail_cnt + 1;
				err_cnt = err_cnt + test_errs;
				test_errs = 0;
				done_cnt = 0;
			end
			if (report)
			begin
				err_cnt = err_cnt + test_errs; // errors after the last entry
				test_errs = 0;
				$display("%0d tests run, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
			end
		end
	end

endmodule

`default_nettype wire

/* tests/tb_i2c.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_i2c;

	typedef struct packed
	{
		logic [6:0] dev;
		logic rw; // 1 = read
		logic [7:0] mem;
		logic [7:0] data; // write byte, or REG_DATA preload on reads
		logic exp_nack;
		logic rnd; // data from the lfsr instead
		logic poke; // second start while busy
	} entry_t;

	logic sclk;
	logic rst;
	logic cfg_wr;
	i2c_pkg::cfg_reg_e cfg_addr;
	logic [7:0] cfg_wdata;
	logic [7:0] cfg_rdata;
	logic busy;
	logic done;
	logic nack;
	logic scl;
	logic sda;
	logic chk_en; // checker compare strobe
	logic [7:0] chk_exp;
	logic exp_nack;
	logic test_end;
	logic [7:0] test_num;
	logic report;
	int err_cnt;
	logic timed_out;
	logic [7:0] lfsr; // random byte source
	logic [7:0] ref_mem [16]; // model of slave storage
	entry_t tbl[$];

	always #4 sclk = ~sclk; // 8 ns period

	i2c_top i2c_top_inst
	(
		.sclk(sclk), .rst(rst), .cfg_wr(cfg_wr), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
		.cfg_rdata(cfg_rdata), .busy(busy), .done(done), .nack(nack), .scl(scl), .sda(sda)
	);

	i2c_checker i2c_checker_inst
	(
		.sclk(sclk), .rst(rst), .done(done), .nack(nack), .busy(busy), .cfg_rdata(cfg_rdata),
		.scl(scl), .sda(sda), .cfg_addr(cfg_addr), .chk_en(chk_en), .chk_exp(chk_exp),
		.exp_nack(exp_nack), .test_end(test_end), .test_num(test_num), .report(report),
		.err_cnt(err_cnt)
	);

	// x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic [7:0] lfsr_next(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	function automatic logic [7:0] rand_byte();
		logic [7:0] b;
		b = '0;
		for (int k = 0; k < 8; k++)
		begin
			lfsr = lfsr_next(lfsr); // one step per bit
			b = {b[6:0], lfsr[0]};
		end
		return b;
	endfunction

	function automatic void add_entry(input logic [6:0] dev, input logic rw,
		input logic [7:0] mem, input logic [7:0] data, input logic exp_nack_e,
		input logic rnd, input logic poke);
		tbl.push_back({dev, rw, mem, data, exp_nack_e, rnd, poke});
	endfunction

	task automatic write_reg(input i2c_pkg::cfg_reg_e a, input logic [7:0] d);
		@(posedge sclk);
		cfg_wr <= 1'b1;
		cfg_addr <= a;
		cfg_wdata <= d;
		@(posedge sclk);
		cfg_wr <= 1'b0;
	endtask

	task automatic check_reg(input i2c_pkg::cfg_reg_e a, input logic [7:0] exp);
		@(posedge sclk);
		cfg_addr <= a; // rdata settles before the next edge
		chk_exp <= exp;
		chk_en <= 1'b1;
		@(posedge sclk);
		chk_en <= 1'b0;
	endtask

	task automatic run_entry(input int idx);
		entry_t e;
		logic [7:0] data;
		logic [7:0] exp_data;
		int n;
		e = tbl[idx];
		data = e.rnd ? rand_byte() : e.data;
		write_reg(i2c_pkg::REG_DEV, {e.dev, e.rw});
		write_reg(i2c_pkg::REG_MEM, e.mem);
		write_reg(i2c_pkg::REG_DATA, data);
		check_reg(i2c_pkg::REG_DEV, {e.dev, e.rw}); // idle readback
		check_reg(i2c_pkg::REG_MEM, e.mem);
		check_reg(i2c_pkg::REG_DATA, data);
		exp_nack <= e.exp_nack;
		write_reg(i2c_pkg::REG_CTRL, 8'h01); // go
		if (e.poke)
		begin
			repeat (20) @(posedge sclk);
			check_reg(i2c_pkg::REG_CTRL, 8'h01); // busy, status cleared
			write_reg(i2c_pkg::REG_CTRL, 8'h01); // must be dropped
		end
		n = 0;
		while (!done && n < 1000)
		begin
			@(negedge sclk); // done stable mid cycle
			n++;
		end
		if (!done)
		begin
			$display("test %0d: no done pulse within 1000 cycles, stopping", idx);
			timed_out = 1'b1;
			return;
		end
		exp_data = (e.rw && !e.exp_nack) ? ref_mem[e.mem[3:0]] : data;
		check_reg(i2c_pkg::REG_CTRL, {5'b0, 1'b1, e.exp_nack, 1'b0}); // idle, done_seen
		check_reg(i2c_pkg::REG_DATA, exp_data);
		if (!e.rw && !e.exp_nack)
			ref_mem[e.mem[3:0]] = data;
		@(posedge sclk);
		test_end <= 1'b1;
		test_num <= 8'(idx);
		@(posedge sclk);
		test_end <= 1'b0;
	endtask

	initial
	begin
		sclk = 1'b0;
		rst = 1'b1;
		cfg_wr = 1'b0;
		cfg_addr = i2c_pkg::REG_DEV;
		cfg_wdata = '0;
		chk_en = 1'b0;
		chk_exp = '0;
		exp_nack = 1'b0;
		test_end = 1'b0;
		test_num = '0;
		report = 1'b0;
		timed_out = 1'b0;
		lfsr = 8'd62; // seed
		for (int k = 0; k < 16; k++)
			ref_mem[k] = '0; // slave clears on reset
		add_entry(i2c_pkg::SLAVE_ADDR, 1'b0, 8'h03, 8'ha5, 1'b0, 1'b0, 1'b0);
		add_entry(i2c_pkg::SLAVE_ADDR, 1'b1, 8'h03, 8'h00, 1'b0, 1'b0, 1'b0);
		add_entry(7'h21, 1'b0, 8'h05, 8'h3c, 1'b1, 1'b0, 1'b0); // wrong device
		add_entry(7'h49, 1'b1, 8'h03, 8'h00, 1'b1, 1'b0, 1'b0);
		add_entry(i2c_pkg::SLAVE_ADDR, 1'b1, 8'h05, 8'h00, 1'b0, 1'b0, 1'b0);
		add_entry(i2c_pkg::SLAVE_ADDR, 1'b0, 8'h10, 8'h77, 1'b1, 1'b0, 1'b0); // out of range
		add_entry(i2c_pkg::SLAVE_ADDR, 1'b0, 8'hc8, 8'h11, 1'b1, 1'b0, 1'b0);
		add_entry(i2c_pkg::SLAVE_ADDR, 1'b1, 8'h10, 8'he7, 1'b1, 1'b0, 1'b0);
		add_entry(i2c_pkg::SLAVE_ADDR, 1'b1, 8'h00, 8'h00, 1'b0, 1'b0, 1'b0); // aliases untouched
		add_entry(i2c_pkg::SLAVE_ADDR, 1'b1, 8'h08, 8'h00, 1'b0, 1'b0, 1'b0);
		add_entry(i2c_pkg::SLAVE_ADDR, 1'b0, 8'h0f, 8'h5a, 1'b0, 1'b0, 1'b1); // start while busy
		add_entry(i2c_pkg::SLAVE_ADDR, 1'b1, 8'h0f, 8'h00, 1'b0, 1'b0, 1'b0);
		for (int a = 0; a < 16; a++)
			add_entry(i2c_pkg::SLAVE_ADDR, 1'b0, 8'(a), 8'h00, 1'b0, 1'b1, 1'b0);
		for (int a = 0; a < 16; a++)
			add_entry(i2c_pkg::SLAVE_ADDR, 1'b1, 8'(a), 8'h00, 1'b0, 1'b0, 1'b0);
		repeat (5) @(posedge sclk);
		rst <= 1'b0;
		for (int i = 0; i < tbl.size() && !timed_out; i++)
			run_entry(i);
		@(posedge sclk);
		report <= 1'b1; // checker prints totals
		@(posedge sclk);
		report <= 1'b0;
		repeat (2) @(posedge sclk);
		if (err_cnt == 0 && !timed_out)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
verilog/i2c_pkg.sv
verilog/i2c_cfg_regs.sv
verilog/i2c_master.sv
verilog/i2c_slave_mem.sv
verilog/i2c_top.sv
tests/i2c_checker.sv
tests/tb_i2c.sv

/* run.sh */
#!/bin/sh
# build with Verilator and run, pass only when the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -j 0 --top-module tb_i2c -f flist.f -o tb_i2c_sim \
	&& ./obj_dir/tb_i2c_sim | tee /dev/stderr | grep -q "Everything OK" \
	&& echo "run.sh: simulation passed" \
	|| { echo "run.sh: simulation did not pass"; exit 1; }
